// File: hdl/plru_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared sizes, vector types and controller states for the 8-way tree
// pseudo-LRU replacement unit. Referenced by scoped name from every block.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package plru_pkg;

    // Cache geometry
    localparam int unsigned NUM_WAYS = 8;
    localparam int unsigned NUM_SETS = 64;
    localparam int unsigned INDEX_W  = 6;

    // One node per internal vertex of the binary tree
    localparam int unsigned TREE_W = NUM_WAYS - 1;

    // One bit per way, used for one-hot way selects and way masks
    typedef logic [NUM_WAYS-1:0] way_t;

    typedef logic [INDEX_W-1:0] index_t;

    // Bit 0 root, bits 3..1 upper subtree (ways 7..4), bits 6..4 lower subtree
    // A node bit of 0 means the upper half was used last
    typedef logic [TREE_W-1:0] tree_t;

    // Controller sequencing
    typedef enum logic [1:0] {
        ST_INIT     = 2'd0,
        ST_IDLE     = 2'd1,
        ST_HIT_WB   = 2'd2,
        ST_EVICT_WB = 2'd3
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: hdl/plru_store.sv
////////////////////////////////////////////////////////////////////////////
// Per-set PLRU tree storage. One read port with registered output, data
// valid the cycle after rd_en_i, and one write port landing at the edge.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module plru_store (
    input  logic             clk_i,
    input  logic             rd_en_i,
    input  plru_pkg::index_t rd_index_i,
    output plru_pkg::tree_t  rd_tree_o,
    input  logic             wr_en_i,
    input  plru_pkg::index_t wr_index_i,
    input  plru_pkg::tree_t  wr_tree_i
);

    // One tree per set
    plru_pkg::tree_t mem [plru_pkg::NUM_SETS];

    // Write port
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem[wr_index_i] <= wr_tree_i;
        end
    end

    // Read port, output held between reads
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_tree_o <= mem[rd_index_i];
        end
    end

endmodule

`default_nettype wire

// File: hdl/plru_hit_update.sv
////////////////////////////////////////////////////////////////////////////
// Combinational hit rule. Every node on the path of the one-hot hit way is
// pointed at the half holding that way; all other nodes are kept.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module plru_hit_update (
    input  plru_pkg::tree_t tree_i,
    input  plru_pkg::way_t  hit_way_i,
    output plru_pkg::tree_t tree_o
);

    logic       root_up;
    logic       quad_up;
    logic       pair_up;
    logic [3:0] quad_ways;
    logic [1:0] pair_ways;
    logic [2:0] quad_node;
    logic [2:0] pair_node;

    always_comb begin
        // Root level, upper half is ways 7..4
        root_up   = |hit_way_i[7:4];
        quad_ways = root_up ? hit_way_i[7:4] : hit_way_i[3:0];
        quad_node = root_up ? 3'd1 : 3'd4;

        // Quarter level inside the chosen subtree
        quad_up   = |quad_ways[3:2];
        pair_ways = quad_up ? quad_ways[3:2] : quad_ways[1:0];
        pair_node = quad_node + 3'd1 + {2'b00, ~quad_up};

        // Pair level
        pair_up = pair_ways[1];

        tree_o = tree_i;
        // No way flagged leaves the tree as it was
        if (hit_way_i != '0) begin
            tree_o[0]         = ~root_up;
            tree_o[quad_node] = ~quad_up;
            tree_o[pair_node] = ~pair_up;
        end
    end

endmodule

`default_nettype wire

// File: hdl/plru_victim_select.sv
////////////////////////////////////////////////////////////////////////////
// Combinational victim walk over the PLRU tree. Locked scratchpad ways are
// steered around at every level and the walked path is written back into
// the returned tree. A fully locked set gives no victim and no change.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module plru_victim_select (
    input  plru_pkg::tree_t tree_i,
    input  plru_pkg::way_t  lock_i,
    output plru_pkg::way_t  victim_o,
    output plru_pkg::tree_t tree_o
);

    // Node decision, returns 1 when the lower half is taken
    function automatic logic pick_half(input logic node,
                                       input logic upper_locked,
                                       input logic lower_locked);
        logic sel;
        if (upper_locked) begin
            sel = 1'b1;
        end else if (lower_locked) begin
            sel = 1'b0;
        end else begin
            // Go away from the half used last
            sel = ~node;
        end
        return sel;
    endfunction

    logic       all_locked;
    logic       root_sel;
    logic       quad_sel;
    logic       pair_sel;
    logic [3:0] quad_lock;
    logic [1:0] pair_lock;
    logic [2:0] quad_node;
    logic [2:0] pair_node;
    logic [2:0] way_idx;

    assign all_locked = &lock_i;

    always_comb begin
        // Root splits ways 7..4 from 3..0
        root_sel  = pick_half(tree_i[0], &lock_i[7:4], &lock_i[3:0]);
        quad_lock = root_sel ? lock_i[3:0] : lock_i[7:4];
        quad_node = root_sel ? 3'd4 : 3'd1;

        // Quarter node of the chosen subtree
        quad_sel  = pick_half(tree_i[quad_node], &quad_lock[3:2], &quad_lock[1:0]);
        pair_lock = quad_sel ? quad_lock[1:0] : quad_lock[3:2];
        pair_node = quad_node + 3'd1 + {2'b00, quad_sel};

        // Pair node picks the single way
        pair_sel = pick_half(tree_i[pair_node], pair_lock[1], pair_lock[0]);

        // Upper halves hold the higher way numbers
        way_idx = {~root_sel, ~quad_sel, ~pair_sel};

        victim_o = '0;
        tree_o   = tree_i;
        if (!all_locked) begin
            victim_o          = plru_pkg::way_t'(1) << way_idx;
            tree_o[0]         = root_sel;
            tree_o[quad_node] = quad_sel;
            tree_o[pair_node] = pair_sel;
        end
    end

endmodule

`default_nettype wire

// File: hdl/plru_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Sequencer of the PLRU unit. Clears every set after reset, then accepts
// one hit or evict at a time: the store is read in the accept cycle and the
// updated tree is written back with the result pulse one cycle later.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module plru_ctrl (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             hit_i,
    input  logic             evict_i,
    input  plru_pkg::index_t index_i,
    input  plru_pkg::way_t   hit_way_i,
    input  plru_pkg::way_t   spm_lock_i,
    input  plru_pkg::way_t   dirty_i,
    output logic             rd_en_o,
    output plru_pkg::index_t rd_index_o,
    output logic             wr_en_o,
    output plru_pkg::index_t wr_index_o,
    output plru_pkg::tree_t  wr_tree_o,
    input  plru_pkg::tree_t  hit_tree_i,
    input  plru_pkg::tree_t  victim_tree_i,
    input  plru_pkg::way_t   victim_i,
    output plru_pkg::way_t   hit_way_o,
    output plru_pkg::way_t   lock_o,
    output logic             busy_o,
    output logic             hit_done_o,
    output logic             victim_valid_o,
    output plru_pkg::way_t   victim_way_o,
    output logic             evict_o
);

    plru_pkg::ctrl_state_e state_q;
    plru_pkg::ctrl_state_e state_d;
    plru_pkg::index_t      sweep_cnt_q;
    plru_pkg::index_t      index_q;
    plru_pkg::way_t        hit_way_q;
    plru_pkg::way_t        lock_q;
    plru_pkg::way_t        dirty_q;
    logic                  accept;
    logic                  sweep_last;

    assign accept     = (state_q == plru_pkg::ST_IDLE) && (hit_i || evict_i);
    assign sweep_last = (sweep_cnt_q == plru_pkg::index_t'(plru_pkg::NUM_SETS - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            plru_pkg::ST_INIT: begin
                if (sweep_last) begin
                    state_d = plru_pkg::ST_IDLE;
                end
            end
            plru_pkg::ST_IDLE: begin
                // Hit wins if both strobes are ever raised together
                if (hit_i) begin
                    state_d = plru_pkg::ST_HIT_WB;
                end else if (evict_i) begin
                    state_d = plru_pkg::ST_EVICT_WB;
                end
            end
            default: begin
                state_d = plru_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= plru_pkg::ST_INIT;
            sweep_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == plru_pkg::ST_INIT) begin
                sweep_cnt_q <= sweep_cnt_q + plru_pkg::index_t'(1);
            end
        end
    end

    // Request payload, held through the writeback cycle
    always_ff @(posedge clk_i) begin
        if (accept) begin
            index_q   <= index_i;
            hit_way_q <= hit_way_i;
            lock_q    <= spm_lock_i;
            dirty_q   <= dirty_i;
        end
    end

    // Store read is issued in the accept cycle itself
    assign rd_en_o    = accept;
    assign rd_index_o = index_i;

    // Sweep writes zero, writeback writes the updated tree
    assign wr_en_o    = (state_q != plru_pkg::ST_IDLE);
    assign wr_index_o = (state_q == plru_pkg::ST_INIT) ? sweep_cnt_q : index_q;

    always_comb begin
        case (state_q)
            plru_pkg::ST_HIT_WB:   wr_tree_o = hit_tree_i;
            plru_pkg::ST_EVICT_WB: wr_tree_o = victim_tree_i;
            default:               wr_tree_o = '0;
        endcase
    end

    assign hit_way_o = hit_way_q;
    assign lock_o    = lock_q;

    assign busy_o         = (state_q != plru_pkg::ST_IDLE);
    assign hit_done_o     = (state_q == plru_pkg::ST_HIT_WB);
    assign victim_valid_o = (state_q == plru_pkg::ST_EVICT_WB);
    assign victim_way_o   = victim_valid_o ? victim_i : '0;

    // Dirty victim needs a writeback by the cache
    assign evict_o = victim_valid_o && ((victim_i & dirty_q) != '0);

endmodule

`default_nettype wire

// File: hdl/plru_top.sv
////////////////////////////////////////////////////////////////////////////
// Top level of the 8-way tree PLRU replacement unit. Joins the controller,
// the per-set tree store and the hit and victim tree rules.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module plru_top (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             hit_i,
    input  logic             evict_i,
    input  plru_pkg::index_t index_i,
    input  plru_pkg::way_t   hit_way_i,
    input  plru_pkg::way_t   spm_lock_i,
    input  plru_pkg::way_t   dirty_i,
    output logic             busy_o,
    output logic             hit_done_o,
    output logic             victim_valid_o,
    output plru_pkg::way_t   victim_way_o,
    output logic             evict_o
);

    logic             rd_en;
    plru_pkg::index_t rd_index;
    plru_pkg::tree_t  rd_tree;
    logic             wr_en;
    plru_pkg::index_t wr_index;
    plru_pkg::tree_t  wr_tree;
    plru_pkg::tree_t  hit_tree;
    plru_pkg::tree_t  victim_tree;
    plru_pkg::way_t   victim;
    plru_pkg::way_t   hit_way;
    plru_pkg::way_t   lock;

    plru_ctrl u_ctrl (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .hit_i          (hit_i),
        .evict_i        (evict_i),
        .index_i        (index_i),
        .hit_way_i      (hit_way_i),
        .spm_lock_i     (spm_lock_i),
        .dirty_i        (dirty_i),
        .rd_en_o        (rd_en),
        .rd_index_o     (rd_index),
        .wr_en_o        (wr_en),
        .wr_index_o     (wr_index),
        .wr_tree_o      (wr_tree),
        .hit_tree_i     (hit_tree),
        .victim_tree_i  (victim_tree),
        .victim_i       (victim),
        .hit_way_o      (hit_way),
        .lock_o         (lock),
        .busy_o         (busy_o),
        .hit_done_o     (hit_done_o),
        .victim_valid_o (victim_valid_o),
        .victim_way_o   (victim_way_o),
        .evict_o        (evict_o)
    );

    plru_store u_store (
        .clk_i      (clk_i),
        .rd_en_i    (rd_en),
        .rd_index_i (rd_index),
        .rd_tree_o  (rd_tree),
        .wr_en_i    (wr_en),
        .wr_index_i (wr_index),
        .wr_tree_i  (wr_tree)
    );

    // Both rules see the tree read in the accept cycle
    plru_hit_update u_hit_update (
        .tree_i    (rd_tree),
        .hit_way_i (hit_way),
        .tree_o    (hit_tree)
    );

    plru_victim_select u_victim_select (
        .tree_i   (rd_tree),
        .lock_i   (lock),
        .victim_o (victim),
        .tree_o   (victim_tree)
    );

endmodule

`default_nettype wire

// File: test/plru_properties.sv
////////////////////////////////////////////////////////////////////////////
// Concurrent assertions on the PLRU controller, attached by bind. Covers
// strobe exclusion, victim encoding, lock respect and result timing.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module plru_properties (
    input logic                  clk_i,
    input logic                  reset_i,
    input logic                  hit_i,
    input logic                  evict_i,
    input plru_pkg::ctrl_state_e state_i,
    input plru_pkg::way_t        lock_i,
    input logic                  hit_done_i,
    input logic                  victim_valid_i,
    input plru_pkg::way_t        victim_way_i
);

    logic accept;
    logic result;

    assign accept = (state_i == plru_pkg::ST_IDLE) && (hit_i || evict_i);
    assign result = hit_done_i || victim_valid_i;

    strobes_exclusive: assert property (
        @(posedge clk_i) disable iff (reset_i) !(hit_i && evict_i)
    ) else $error("hit and evict strobes high in the same cycle");

    victim_onehot0: assert property (
        @(posedge clk_i) disable iff (reset_i) $onehot0(victim_way_i)
    ) else $error("victim way is neither one-hot nor zero");

    victim_not_locked: assert property (
        @(posedge clk_i) disable iff (reset_i)
        victim_valid_i |-> ((victim_way_i & lock_i) == '0)
    ) else $error("victim way is locked as scratchpad");

    // Result pulse exactly one cycle after acceptance, and only then
    result_after_accept: assert property (
        @(posedge clk_i) disable iff (reset_i) accept |=> result
    ) else $error("no result pulse one cycle after an accepted request");

    result_needs_accept: assert property (
        @(posedge clk_i) disable iff (reset_i) result |-> $past(accept)
    ) else $error("result pulse without an accepted request");

endmodule

bind plru_ctrl plru_properties u_properties (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .hit_i          (hit_i),
    .evict_i        (evict_i),
    .state_i        (state_q),
    .lock_i         (lock_q),
    .hit_done_i     (hit_done_o),
    .victim_valid_i (victim_valid_o),
    .victim_way_i   (victim_way_o)
);

`default_nettype wire

// File: test/plru_checker.sv
////////////////////////////////////////////////////////////////////////////
// Reference model and comparator for the PLRU unit. Watches the DUT ports,
// keeps its own trees per set and checks every result pulse.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module plru_checker (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             hit_i,
    input  logic             evict_i,
    input  plru_pkg::index_t index_i,
    input  plru_pkg::way_t   hit_way_i,
    input  plru_pkg::way_t   spm_lock_i,
    input  plru_pkg::way_t   dirty_i,
    input  logic             busy_i,
    input  logic             hit_done_i,
    input  logic             victim_valid_i,
    input  plru_pkg::way_t   victim_way_i,
    input  logic             dirty_evict_i,
    output int               errors_o,
    output int               checks_o
);

    plru_pkg::tree_t model [plru_pkg::NUM_SETS];
    plru_pkg::way_t  exp_way;
    logic            exp_hit;
    logic            exp_vic;
    logic            exp_evict;
    logic            sweep_done;
    int              sweep_cycles;

    initial begin
        errors_o = 0;
        checks_o = 0;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks_o = checks_o + 1;
        if (actual !== expected) begin
            $display("ERROR t=%0t %s expected %0h got %0h", $time, name, expected, actual);
            errors_o = errors_o + 1;
        end
    endtask

    // Every node on the path points at the half holding the hit way
    function automatic plru_pkg::tree_t mark_hit_path(input plru_pkg::tree_t tree,
                                                      input plru_pkg::way_t onehot);
        plru_pkg::tree_t t;
        int way;
        int node;
        int lo;
        int size;
        int half;
        t = tree;
        way = 0;
        for (int i = 0; i < 8; i++) begin
            if (((onehot >> i) & 8'h01) != 8'h00) begin
                way = i;
            end
        end
        node = 0;
        lo = 0;
        size = plru_pkg::NUM_WAYS;
        while (size > 1) begin
            half = size / 2;
            if (way >= lo + half) begin
                t[node[2:0]] = 1'b0;
                node = node + 1;
                lo = lo + half;
            end else begin
                t[node[2:0]] = 1'b1;
                node = node + half;
            end
            size = half;
        end
        return t;
    endfunction

    // Walk from the root, steering around fully locked halves
    function automatic plru_pkg::way_t pick_victim(input plru_pkg::tree_t tree,
                                                   input plru_pkg::way_t lock,
                                                   output plru_pkg::tree_t t);
        plru_pkg::way_t low_mask;
        plru_pkg::way_t up_mask;
        logic take_lower;
        int node;
        int lo;
        int size;
        int half;
        t = tree;
        if (lock == 8'hff) begin
            return '0;
        end
        node = 0;
        lo = 0;
        size = plru_pkg::NUM_WAYS;
        while (size > 1) begin
            half = size / 2;
            low_mask = ((8'h01 << half) - 8'h01) << lo;
            up_mask = low_mask << half;
            if ((lock & up_mask) == up_mask) begin
                take_lower = 1'b1;
            end else if ((lock & low_mask) == low_mask) begin
                take_lower = 1'b0;
            end else begin
                take_lower = ~t[node[2:0]];
            end
            t[node[2:0]] = take_lower;
            if (take_lower) begin
                node = node + half;
            end else begin
                node = node + 1;
                lo = lo + half;
            end
            size = half;
        end
        return plru_pkg::way_t'(1) << lo;
    endfunction

    always @(posedge clk_i) begin
        if (reset_i) begin
            for (int s = 0; s < plru_pkg::NUM_SETS; s++) begin
                model[s[5:0]] = '0;
            end
            exp_hit = 1'b0;
            exp_vic = 1'b0;
            sweep_done = 1'b0;
            sweep_cycles = 0;
        end else begin
            if (!sweep_done) begin
                if (busy_i) begin
                    sweep_cycles = sweep_cycles + 1;
                end else begin
                    sweep_done = 1'b1;
                    check_value("busy_o cycles after reset", 32'(plru_pkg::NUM_SETS),
                                32'(sweep_cycles));
                end
            end

            // Busy only in the cycle after an accepted request
            if (sweep_done) begin
                check_value("busy_o", 32'(exp_hit || exp_vic), 32'(busy_i));
            end

            // Outputs of the request accepted at the previous edge
            check_value("hit_done_o", 32'(exp_hit), 32'(hit_done_i));
            check_value("victim_valid_o", 32'(exp_vic), 32'(victim_valid_i));
            if (exp_vic) begin
                check_value("victim_way_o", 32'(exp_way), 32'(victim_way_i));
                check_value("evict_o", 32'(exp_evict), 32'(dirty_evict_i));
            end else begin
                check_value("victim_way_o", 32'h0, 32'(victim_way_i));
                check_value("evict_o", 32'h0, 32'(dirty_evict_i));
            end

            exp_hit = 1'b0;
            exp_vic = 1'b0;
            if (sweep_done && !busy_i && (hit_i || evict_i)) begin
                if (hit_i) begin
                    model[index_i] = mark_hit_path(model[index_i], hit_way_i);
                    exp_hit = 1'b1;
                end else begin
                    exp_way = pick_victim(model[index_i], spm_lock_i, model[index_i]);
                    exp_evict = (exp_way & dirty_i) != '0;
                    exp_vic = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: test/plru_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench top for the PLRU unit. Drives seeded random hits and evicts,
// runs the checker alongside the DUT and prints the per-test results.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module plru_tb;

    localparam int CLK_PERIOD = 40;
    // Requests issued by all tests together
    localparam int TOTAL_REQ  = 4 + 32 + 200 + 66 + 40 + 10;
    localparam int MARGIN     = 100;
    localparam int TIMEOUT    = (plru_pkg::NUM_SETS + 2 * TOTAL_REQ + MARGIN) * CLK_PERIOD;

    logic             clk = 1'b0;
    logic             reset;
    logic             hit;
    logic             evict;
    plru_pkg::index_t index;
    plru_pkg::way_t   hit_way;
    plru_pkg::way_t   spm_lock;
    plru_pkg::way_t   dirty;
    logic             busy;
    logic             hit_done;
    logic             victim_valid;
    plru_pkg::way_t   victim_way;
    logic             evict_flag;
    int               errors;
    int               checks;
    int               tb_errors;
    int               test_num;
    int               prev_errors;
    integer           seed;
    logic [31:0]      rnd;
    plru_pkg::index_t set_sel;

    always #(CLK_PERIOD / 2) clk = ~clk;

    plru_top DUT (
        .clk_i          (clk),
        .reset_i        (reset),
        .hit_i          (hit),
        .evict_i        (evict),
        .index_i        (index),
        .hit_way_i      (hit_way),
        .spm_lock_i     (spm_lock),
        .dirty_i        (dirty),
        .busy_o         (busy),
        .hit_done_o     (hit_done),
        .victim_valid_o (victim_valid),
        .victim_way_o   (victim_way),
        .evict_o        (evict_flag)
    );

    plru_checker u_checker (
        .clk_i          (clk),
        .reset_i        (reset),
        .hit_i          (hit),
        .evict_i        (evict),
        .index_i        (index),
        .hit_way_i      (hit_way),
        .spm_lock_i     (spm_lock),
        .dirty_i        (dirty),
        .busy_i         (busy),
        .hit_done_i     (hit_done),
        .victim_valid_i (victim_valid),
        .victim_way_i   (victim_way),
        .dirty_evict_i  (evict_flag),
        .errors_o       (errors),
        .checks_o       (checks)
    );

    task automatic next_random();
        rnd = $random(seed);
    endtask

    task automatic wait_idle();
        while (busy) begin
            @(posedge clk);
            #2;
        end
    endtask

    // One strobe cycle once the DUT is idle
    task automatic send_request(input logic is_hit, input plru_pkg::index_t idx,
                                input plru_pkg::way_t way, input plru_pkg::way_t lock,
                                input plru_pkg::way_t drt);
        wait_idle();
        hit = is_hit;
        evict = ~is_hit;
        index = idx;
        hit_way = way;
        spm_lock = lock;
        dirty = drt;
        @(posedge clk);
        #2;
        hit = 1'b0;
        evict = 1'b0;
    endtask

    // Strobe raised in the writeback cycle, which the DUT must ignore
    task automatic raise_while_busy(input logic is_hit, input plru_pkg::index_t idx);
        if (!busy) begin
            $display("ERROR t=%0t busy_o expected 1 got %0b", $time, busy);
            tb_errors = tb_errors + 1;
        end
        hit = is_hit;
        evict = ~is_hit;
        index = idx;
        hit_way = 8'h01;
        @(posedge clk);
        #2;
        hit = 1'b0;
        evict = 1'b0;
    endtask

    task automatic finish_test(input string name);
        int new_errors;
        repeat (2) begin
            @(posedge clk);
            #2;
        end
        test_num = test_num + 1;
        new_errors = errors + tb_errors - prev_errors;
        prev_errors = errors + tb_errors;
        $display("test %0d %s: %s (%0d errors)", test_num, name,
                 (new_errors == 0) ? "ok" : "FAILED", new_errors);
    endtask

    initial begin
        #(TIMEOUT);
        $display("watchdog expired before the tests finished");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        seed = 32'hd5e6;
        tb_errors = 0;
        test_num = 0;
        prev_errors = 0;
        reset = 1'b1;
        hit = 1'b0;
        evict = 1'b0;
        index = '0;
        hit_way = '0;
        spm_lock = '0;
        dirty = '0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        // Fresh sets point at way 0 after the sweep
        for (int i = 0; i < 4; i++) begin
            send_request(1'b0, plru_pkg::index_t'(i * 13), '0, '0, '0);
        end
        finish_test("reset sweep and fresh evict");

        for (int i = 0; i < 16; i++) begin
            next_random();
            set_sel = rnd[5:0];
            send_request(1'b1, set_sel, 8'h01 << rnd[8:6], '0, '0);
            send_request(1'b0, set_sel, '0, '0, '0);
        end
        finish_test("hit then evict");

        for (int i = 0; i < 200; i++) begin
            next_random();
            send_request(rnd[0], plru_pkg::index_t'(rnd[4:1]), 8'h01 << rnd[7:5],
                         rnd[15:8] & rnd[23:16], rnd[31:24]);
        end
        finish_test("random mix");

        for (int i = 0; i < 60; i++) begin
            next_random();
            set_sel = plru_pkg::index_t'(rnd[3:0]);
            if (i % 10 == 9) begin
                // Fully locked set, then an unlocked evict sees the old tree
                send_request(1'b0, set_sel, '0, 8'hff, rnd[15:8]);
                send_request(1'b0, set_sel, '0, '0, rnd[15:8]);
            end else begin
                case (rnd[5:4])
                    2'd0: spm_lock = rnd[15:8];
                    2'd1: spm_lock = 8'hf0 | rnd[15:8];
                    2'd2: spm_lock = 8'h0f | rnd[15:8];
                    default: spm_lock = rnd[15:8] & rnd[23:16];
                endcase
                send_request(1'b0, set_sel, '0, spm_lock, rnd[31:24]);
            end
        end
        finish_test("scratchpad locks");

        for (int i = 0; i < 40; i++) begin
            next_random();
            send_request(1'b0, rnd[5:0], '0, rnd[15:8] & rnd[23:16], rnd[31:24]);
        end
        finish_test("dirty victims");

        for (int i = 0; i < 10; i++) begin
            next_random();
            send_request(rnd[0], rnd[6:1], 8'h01 << rnd[9:7], '0, rnd[17:10]);
            raise_while_busy(~rnd[0], rnd[23:18]);
        end
        finish_test("requests while busy");

        $display("summary: %0d tests, %0d checks, %0d errors", test_num, checks,
                 errors + tb_errors);
        if (errors == 0 && tb_errors == 0 && checks > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
hdl/plru_pkg.sv
hdl/plru_store.sv
hdl/plru_hit_update.sv
hdl/plru_victim_select.sv
hdl/plru_ctrl.sv
hdl/plru_top.sv
test/plru_properties.sv
test/plru_checker.sv
test/plru_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = plru_tb
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
